//--- verif/vector_cfg_tests.txt
// instruction rs1_data rs2_data exp_is_vec exp_error exp_csr_out, all hex
// keep-vl lines (rs1 = rd = x0) expect the vl of the last config line before them
010572D7 00000003 00000000 1 0 00000003
001572D7 00000064 00000000 1 0 00000020
0CA572D7 0000001F 00000000 1 0 0000001F
C008F357 DEADBEEF 00000000 1 0 00000010
C134F357 00000000 00000000 1 0 00000009
80B573D7 00000032 00000009 1 0 00000010
80B573D7 00000005 0000000A 1 0 00000005
011072D7 00000003 00000000 1 0 00000008
00007057 00000000 00000000 1 0 00000008
018572D7 00000004 00000000 1 1 00000000
00007057 00000000 00000000 1 0 00000000
000572D7 0000000C 00000000 1 0 0000000C
005572D7 00000004 00000000 1 1 00000000
C083F357 00000000 00000000 1 0 00000007
80B573D7 00000003 00000100 1 1 00000000
000572D7 0000000A 00000000 1 0 0000000A
00100093 00000011 00000022 0 0 00000000
022080D7 00000033 00000044 0 0 00000000
00007057 00000000 00000000 1 0 0000000A
82007057 00000005 00000009 0 0 00000000

//--- all.f
hdl/vec_isa_pkg.sv
hdl/vec_cfg_pkg.sv
hdl/vec_cfg_decode.sv
hdl/cfg_queue.sv
hdl/vl_config_unit.sv
hdl/vector_cfg_top.sv
verif/vector_cfg_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the vector config testbench with Verilator.
# Run from any directory; all paths are taken relative to the project root.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns -f all.f \
    --top-module vector_cfg_tb -Mdir obj_dir -o vector_cfg_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/vector_cfg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi
exit 0

//--- verif/vector_cfg_tb.sv
/* Reads num_tests lines from verif/vector_cfg_tests.txt relative to the project root
   scalar_pro_ready starts low for stall_cycles so the queue is forced full once */
`timescale 1ns/1ns

module vector_cfg_tb
    import vec_cfg_pkg::*;
();

    localparam int num_tests      = 20;
    localparam int words_per_test = 6;                     // inst, rs1, rs2, is_vec, error, csr_out
    localparam int cycle_limit    = 40 * num_tests + 100;
    localparam int stall_cycles   = 12;                    // Early back-pressure window
    localparam int max_in_flight  = 5;                     // Four queue entries plus one held result

    logic            clk              = 1'b0;
    logic            reset            = 1'b0;
    logic            inst_valid       = 1'b0;
    logic [xlen-1:0] instruction      = '0;
    logic [xlen-1:0] rs1_data         = '0;
    logic [xlen-1:0] rs2_data         = '0;
    logic            scalar_pro_ready = 1'b0;
    logic            vec_pro_ready;
    logic            vec_pro_ack;
    logic            is_vec;
    logic            error;
    logic [xlen-1:0] csr_out;

    logic [xlen-1:0] tests [128];        // Six words per test
    logic [15:0]     lfsr = 16'd31462;
    logic [6:0]      idx;
    logic [2:0]      rnd;
    logic            accepted;
    int              sent         = 0;   // Offers taken by the DUT
    int              checked      = 0;   // Results compared
    int              in_flight    = 0;   // Accepted but not yet taken
    int              cycles       = 0;
    int              full_cycles  = 0;
    int              value_errors = 0;
    int              flow_errors  = 0;

    vector_cfg_top vector_cfg_top_inst (
        .clk              (clk),
        .reset            (reset),
        .inst_valid       (inst_valid),
        .instruction      (instruction),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .scalar_pro_ready (scalar_pro_ready),
        .vec_pro_ready    (vec_pro_ready),
        .vec_pro_ack      (vec_pro_ack),
        .is_vec           (is_vec),
        .error            (error),
        .csr_out          (csr_out)
    );

    always #10 clk = ~clk;   // 20 ns period

    initial begin
        $readmemh("verif/vector_cfg_tests.txt", tests);
        repeat (2) @(posedge clk);
        reset <= 1'b1;   // Two edges seen in reset
    end

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [2:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);        // One step per bit
            bits = {bits[1:0], lfsr[0]};
        end
    endtask

    // Compare the held result with the next expected line
    task automatic check_result;
        logic [6:0] base;
        base = 7'(checked * words_per_test);
        if (is_vec != tests[base + 7'd3][0]) begin
            $display("ERROR at %0t ns: test %0d is_vec %0b, expected %0b",
                     $time, checked, is_vec, tests[base + 7'd3][0]);
            value_errors++;
        end
        if (error != tests[base + 7'd4][0]) begin
            $display("ERROR at %0t ns: test %0d error %0b, expected %0b",
                     $time, checked, error, tests[base + 7'd4][0]);
            value_errors++;
        end
        if (csr_out != tests[base + 7'd5]) begin
            $display("ERROR at %0t ns: test %0d csr_out %h, expected %h",
                     $time, checked, csr_out, tests[base + 7'd5]);
            value_errors++;
        end
        checked++;
    endtask

    task automatic finish_run;
        $display("Checked %0d of %0d results, value errors %0d, flow errors %0d",
                 checked, num_tests, value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            cycles++;
            // Ready must fall exactly when queue and result slot are both occupied
            if (vec_pro_ready != (in_flight != max_in_flight)) begin
                $display("ERROR at %0t ns: vec_pro_ready %0b with %0d in flight",
                         $time, vec_pro_ready, in_flight);
                flow_errors++;
            end
            if (!vec_pro_ready)
                full_cycles++;
            if (vec_pro_ack && scalar_pro_ready) begin   // Result taken at this edge
                if (in_flight == 0) begin
                    $display("A result was offered at %0t ns with no instruction outstanding",
                             $time);
                    flow_errors++;
                end
                check_result();
                in_flight--;
            end
            accepted = inst_valid && vec_pro_ready;
            if (accepted) begin
                sent++;
                in_flight++;
            end
            // One random bit may add an idle cycle after an accept
            if (sent == num_tests) begin
                inst_valid <= 1'b0;
            end else if (accepted || !inst_valid) begin
                rnd = '0;
                if (accepted)
                    take_bits(1, rnd);
                if (rnd[0]) begin
                    inst_valid <= 1'b0;
                end else begin
                    idx = 7'(sent * words_per_test);
                    inst_valid  <= 1'b1;
                    instruction <= tests[idx];
                    rs1_data    <= tests[idx + 7'd1];
                    rs2_data    <= tests[idx + 7'd2];
                end
            end
            take_bits(3, rnd);
            scalar_pro_ready <= (cycles >= stall_cycles) && (rnd >= 3'd3);  // Low 3 of 8
            if (checked == num_tests) begin
                if (full_cycles == 0) begin
                    $display("The queue never became full during the run");
                    flow_errors++;
                end
                finish_run();
            end else if (cycles >= cycle_limit) begin
                $display("Timeout after %0d cycles with %0d of %0d results checked",
                         cycles, checked, num_tests);
                flow_errors++;
                finish_run();
            end
        end
    end

endmodule

//--- hdl/vector_cfg_top.sv
/* Scalar-side wrapper of the vector config path: decode, queue, config unit
   An instruction is taken on an edge with inst_valid and vec_pro_ready high */
`timescale 1ns/1ns

module vector_cfg_top
    import vec_cfg_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            inst_valid,
    input  logic [xlen-1:0] instruction,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic            scalar_pro_ready,
    output logic            vec_pro_ready,
    output logic            vec_pro_ack,
    output logic            is_vec,
    output logic            error,
    output logic [xlen-1:0] csr_out
);

    logic        req_valid;
    cfg_req_t    req;          // Decoder to queue
    cfg_req_t    head;         // Queue to config unit
    logic        head_valid;
    logic        pop;
    cfg_result_t result;

    vec_cfg_decode vec_cfg_decode_inst (
        .inst_valid  (inst_valid),
        .instruction (instruction),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .req_valid   (req_valid),
        .req         (req)
    );

    cfg_queue cfg_queue_inst (
        .clk        (clk),
        .reset      (reset),
        .push       (req_valid),
        .push_req   (req),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .not_full   (vec_pro_ready)   // Ready whenever a slot is free
    );

    vl_config_unit vl_config_unit_inst (
        .clk              (clk),
        .reset            (reset),
        .head             (head),
        .head_valid       (head_valid),
        .scalar_pro_ready (scalar_pro_ready),
        .pop              (pop),
        .vec_pro_ack      (vec_pro_ack),
        .result           (result)
    );

    assign is_vec  = result.is_vec;
    assign error   = result.error;
    assign csr_out = result.csr_out;

endmodule

//--- hdl/vl_config_unit.sv
/* Holds vl and vtype, computes the new vl from the head request on a pop edge
   Integer LMUL only; vlmul 4..7, SEW above ELEN or reserved bits set give vill */
`timescale 1ns/1ns

module vl_config_unit
    import vec_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  cfg_req_t    head,
    input  logic        head_valid,
    input  logic        scalar_pro_ready,
    output logic        pop,
    output logic        vec_pro_ack,
    output cfg_result_t result
);

    logic [xlen-1:0] vl_q;          // Current vl CSR
    vtype_t          vtype_q;       // Current vtype CSR
    logic            held;          // Result waiting for the scalar side
    logic            taken;
    logic [xlen-1:0] sew;
    logic [xlen-1:0] vlmax;
    logic            illegal;
    logic [xlen-1:0] vl_new;        // vl for a legal request
    logic [xlen-1:0] vl_next;
    vtype_t          vtype_next;
    cfg_result_t     result_next;

    // Take a new head when the output slot is free or being emptied now
    assign taken       = held && scalar_pro_ready;
    assign pop         = head_valid && (!held || scalar_pro_ready);
    assign vec_pro_ack = held;

    assign sew = xlen'(8) << head.vtype.vsew;

    // VLMAX = VLEN / SEW * LMUL, written as shifts
    assign vlmax = (xlen'(vlen / 8) >> head.vtype.vsew) << head.vtype.vlmul[1:0];

    assign illegal = (sew > xlen'(elen))
                   || head.vtype.vlmul[2]       // Fractional or reserved LMUL
                   || (|head.vtype.reserved);

    always_comb begin
        case (head.avl_sel)
            avl_rs1,
            avl_uimm: vl_new = (head.avl < vlmax) ? head.avl : vlmax;  // min(AVL, VLMAX)
            avl_max:  vl_new = vlmax;
            default:  vl_new = vl_q;   // avl_keep
        endcase
    end

    always_comb begin
        vl_next     = vl_q;
        vtype_next  = vtype_q;
        result_next = '0;          // Non-config word reports all zero
        if (head.is_vec) begin
            result_next.is_vec = 1'b1;
            if (illegal) begin
                vl_next            = '0;
                vtype_next         = '0;
                vtype_next.vill    = 1'b1;
                result_next.error  = 1'b1;
            end else begin
                vl_next             = vl_new;
                vtype_next          = head.vtype;
                vtype_next.vill     = 1'b0;
                result_next.csr_out = vl_new;   // New vl back to rd
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            vl_q         <= '0;
            vtype_q      <= '0;
            vtype_q.vill <= 1'b1;   // No valid configuration yet
            held         <= 1'b0;
            result       <= '0;
        end else if (pop) begin
            vl_q    <= vl_next;
            vtype_q <= vtype_next;
            result  <= result_next;
            held    <= 1'b1;        // Also covers take and reload on one edge
        end else if (taken) begin
            held <= 1'b0;
        end
    end

endmodule

//--- hdl/cfg_queue.sv
/* Circular FIFO of decoded requests, no bypass, head is valid one edge after push
   Push while full is ignored; the top level exports not_full as vec_pro_ready */
`timescale 1ns/1ns

module cfg_queue
    import vec_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  cfg_req_t push_req,
    input  logic     pop,
    output cfg_req_t head,
    output logic     head_valid,
    output logic     not_full
);

    cfg_req_t               entries [queue_depth];  // Storage, no reset
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_ptr_w:0]   count;                  // Occupancy, 0..queue_depth
    logic                   do_push;
    logic                   do_pop;

    assign not_full   = (count != (queue_ptr_w + 1)'(queue_depth));
    assign head_valid = (count != '0);
    assign do_push    = push && not_full;
    assign do_pop     = pop && head_valid;   // Guard against pop on empty

    assign head = entries[rd_ptr];

    // Pointers and occupancy
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at queue_depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Entry write
    always_ff @(posedge clk) begin
        if (do_push)
            entries[wr_ptr] <= push_req;
    end

endmodule

//--- hdl/vec_cfg_decode.sv
/* Purely combinational, req follows the inputs in the same cycle
   Words outside the three config forms give is_vec 0 */
`timescale 1ns/1ns

module vec_cfg_decode
    import vec_isa_pkg::*;
    import vec_cfg_pkg::*;
(
    input  logic            inst_valid,
    input  vcfg_inst_u      instruction,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output logic            req_valid,
    output cfg_req_t        req
);

    vsetvl_fmt_t vsetvl_view;   // Third layout, outside the union
    logic        is_cfg;        // OP-V with OPCFG funct3
    logic        is_vli;
    logic        is_ivli;
    logic        is_vl;

    assign vsetvl_view = vsetvl_fmt_t'(instruction);

    // opcode and funct3 sit at the same place in every layout
    assign is_cfg  = (instruction.vli.opcode == op_v_opcode) &&
                     (instruction.vli.funct3 == opcfg_funct3);
    assign is_vli  = (instruction.vli.zero == 1'b0);
    assign is_ivli = (instruction.vivli.marker == vsetivli_marker);
    assign is_vl   = (vsetvl_view.funct7 == vsetvl_funct7);  // Bits 31:30 = 10 only

    assign req_valid = inst_valid;

    always_comb begin
        req         = '0;
        req.avl_sel = avl_rs1;
        req.avl     = rs1_data;
        if (is_cfg && (is_vli || is_ivli || is_vl)) begin
            req.is_vec = 1'b1;
            if (is_ivli) begin
                req.avl_sel = avl_uimm;                          // Always immediate AVL
                req.avl     = xlen'(instruction.vivli.uimm);
                req.vtype   = vtype_t'(xlen'(instruction.vivli.zimm));
            end else begin
                // vsetvli immediate, vsetvl register
                if (is_vli)
                    req.vtype = vtype_t'(xlen'(instruction.vli.zimm));
                else
                    req.vtype = vtype_t'(rs2_data);
                // rs1 and rd share positions in vsetvli and vsetvl
                if (instruction.vli.rs1 != 5'd0)
                    req.avl_sel = avl_rs1;
                else if (instruction.vli.rd != 5'd0)
                    req.avl_sel = avl_max;   // Ask for the largest vl
                else
                    req.avl_sel = avl_keep;  // Change vtype, keep vl
            end
        end
    end

endmodule

//--- hdl/vec_cfg_pkg.sv
/* Machine constants and request/result records of the vector config path
   queue_depth must stay a power of two, the queue pointers wrap naturally */
package vec_cfg_pkg;

    localparam int xlen        = 32;   // Scalar word
    localparam int vlen        = 128;  // Bits per vector register
    localparam int elen        = 32;   // Widest element supported
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = $clog2(queue_depth);

    // vtype CSR layout, XLEN wide
    typedef struct packed {
        logic        vill;       // Illegal configuration flag
        logic [22:0] reserved;   // Must be zero
        logic        vma;
        logic        vta;
        logic [2:0]  vsew;       // SEW = 8 << vsew
        logic [2:0]  vlmul;      // Integer LMUL only, 0..3
    } vtype_t;

    // Where the application vector length comes from
    typedef enum logic [1:0] {
        avl_rs1  = 2'd0,   // rs1_data
        avl_uimm = 2'd1,   // 5-bit immediate of vsetivli
        avl_max  = 2'd2,   // rs1 = x0, rd != x0
        avl_keep = 2'd3    // rs1 = x0, rd = x0
    } avl_sel_t;

    // Decoded request as it sits in the queue
    typedef struct packed {
        logic            is_vec;
        avl_sel_t        avl_sel;
        logic [xlen-1:0] avl;
        vtype_t          vtype;     // Requested, not yet checked
    } cfg_req_t;

    // Result shown to the scalar side
    typedef struct packed {
        logic            is_vec;
        logic            error;
        logic [xlen-1:0] csr_out;
    } cfg_result_t;

endpackage

//--- hdl/vec_isa_pkg.sv
/* RVV configuration instruction encodings (vsetvli, vsetivli, vsetvl)
   Only the OP-V major opcode with the OPCFG funct3 is described here */
package vec_isa_pkg;

    localparam logic [6:0] op_v_opcode     = 7'b1010111;  // OP-V major opcode
    localparam logic [2:0] opcfg_funct3    = 3'b111;      // Configuration class
    localparam logic [1:0] vsetivli_marker = 2'b11;       // Bits 31:30 of vsetivli
    localparam logic [6:0] vsetvl_funct7   = 7'b1000000;  // Bits 31:25 of vsetvl

    // vsetvli rd, rs1, vtypei
    typedef struct packed {
        logic       zero;       // Always 0 for this form
        logic [10:0] zimm;      // vtype immediate
        logic [4:0] rs1;        // AVL register
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } vsetvli_fmt_t;

    // vsetivli rd, uimm, vtypei
    typedef struct packed {
        logic [1:0] marker;     // Must read 11
        logic [9:0] zimm;       // Shorter vtype immediate
        logic [4:0] uimm;       // AVL as a small immediate
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } vsetivli_fmt_t;

    // vsetvl rd, rs1, rs2 (vtype from a register)
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } vsetvl_fmt_t;

    // Same word seen through both immediate layouts
    typedef union packed {
        vsetvli_fmt_t  vli;
        vsetivli_fmt_t vivli;
    } vcfg_inst_u;

endpackage
